//--- src/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// --------------------
// word and line geometry
// --------------------

// one LC-3b word is two bytes.
`define CACHE_WORD_WIDTH 16

// a line holds eight words.
`define CACHE_LINE_WIDTH 128

// address bits 15 down to 4 identify a line.
`define CACHE_TAG_WIDTH 12

// address bits 3 down to 1 pick the word within a line.
`define CACHE_OFFSET_WIDTH 3

`define CACHE_MASK_WIDTH 2  // one enable per byte of a word.

`endif

//--- src/lc3b_types.sv
`default_nettype none

`include "cache_params.svh"

package lc3b_types;

    typedef logic [`CACHE_WORD_WIDTH-1:0] lc3b_word;          // word or byte address.
    typedef logic [`CACHE_MASK_WIDTH-1:0] lc3b_mem_wmask;     // bit 0 is the low byte.
    typedef logic [`CACHE_LINE_WIDTH-1:0] lc3b_cacheline_word; // word 0 sits in the low bits.
    typedef logic [`CACHE_TAG_WIDTH-1:0] lc3b_cacheline_tag;
    typedef logic [`CACHE_OFFSET_WIDTH-1:0] lc3b_cacheline_offset;

    // --------------------
    // address decode
    // --------------------

    // field view of a CPU byte address, most significant field first.
    typedef struct packed {
        lc3b_cacheline_tag tag;
        lc3b_cacheline_offset offset;
        logic byte_sel;  // selects the byte within a word.
    } lc3b_address_fields;

    // the same 16 bits seen either as a raw word or split into fields.
    typedef union packed {
        lc3b_word word;
        lc3b_address_fields fields;
    } lc3b_address;

endpackage : lc3b_types

`default_nettype wire

//--- src/cacheline_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_params.svh"

interface cacheline_if;

    // --------------------
    // datapath to line
    // --------------------
    logic load;      // masked write of one word.
    logic load_all;  // whole line refill from memory.
    logic [`CACHE_TAG_WIDTH-1:0] tag_in;
    logic [`CACHE_OFFSET_WIDTH-1:0] offset;
    logic [`CACHE_MASK_WIDTH-1:0] byte_enable;
    logic [`CACHE_WORD_WIDTH-1:0] data_in;
    logic [`CACHE_LINE_WIDTH-1:0] data_all_in;

    // --------------------
    // line to datapath
    // --------------------
    logic hit;
    logic dirty;
    logic [`CACHE_TAG_WIDTH-1:0] tag_out;
    logic [`CACHE_WORD_WIDTH-1:0] data_out;       // word picked by offset.
    logic [`CACHE_LINE_WIDTH-1:0] data_all_out;   // whole line for a write-back.

    modport datapath (
        output load, load_all, tag_in, offset, byte_enable, data_in, data_all_in,
        input hit, dirty, tag_out, data_out, data_all_out
    );

    modport line (
        input load, load_all, tag_in, offset, byte_enable, data_in, data_all_in,
        output hit, dirty, tag_out, data_out, data_all_out
    );

endinterface : cacheline_if

`default_nettype wire

//--- src/cacheline_128.sv
`timescale 1ns/100ps
`default_nettype none

module cacheline_128 (
    input logic clk,
    input logic rst_n,
    cacheline_if.line port
);

    import lc3b_types::*;

    logic valid_bit;
    logic dirty_bit;
    lc3b_cacheline_tag tag_bits;
    lc3b_cacheline_word data_bits;
    lc3b_word old_word;
    lc3b_word merged_word;

    // --------------------
    // status bits
    // --------------------

    // a refill always leaves the line clean, so it wins over a word write.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_bit <= 1'b0;
            dirty_bit <= 1'b0;
        end else if (port.load_all) begin
            valid_bit <= 1'b1;
            dirty_bit <= 1'b0;
        end else if (port.load) begin
            dirty_bit <= 1'b1;  // line now differs from memory.
        end
    end

    // --------------------
    // tag and data storage
    // --------------------
    always_ff @(posedge clk) begin
        if (port.load_all) begin
            tag_bits <= port.tag_in;
            data_bits <= port.data_all_in;
        end else if (port.load) begin
            data_bits[port.offset * $bits(lc3b_word) +: $bits(lc3b_word)] <= merged_word;
        end
    end

    // the current word at the requested offset.
    assign old_word = data_bits[port.offset * $bits(lc3b_word) +: $bits(lc3b_word)];

    // Only the enabled bytes take the CPU data, the rest keep their old value.
    always_comb begin
        merged_word = old_word;
        if (port.byte_enable[0]) begin
            merged_word[7:0] = port.data_in[7:0];
        end
        if (port.byte_enable[1]) begin
            merged_word[15:8] = port.data_in[15:8];
        end
    end

    // --------------------
    // outputs
    // --------------------
    assign port.hit = valid_bit && (tag_bits == port.tag_in);
    assign port.dirty = dirty_bit;
    assign port.tag_out = tag_bits;
    assign port.data_out = old_word;
    assign port.data_all_out = data_bits;

endmodule : cacheline_128

`default_nettype wire

//--- src/cache_datapath.sv
`timescale 1ns/100ps
`default_nettype none

module cache_datapath (
    input logic clk,
    input logic rst_n,

    // from control.
    input logic cacheline_sel,
    input logic tag_source_sel,
    input logic load,
    input logic load_all,
    input logic load_lru,
    input logic lru_in,

    // from the CPU.
    input lc3b_types::lc3b_word cpu_address,
    input lc3b_types::lc3b_word cpu_wdata,
    input lc3b_types::lc3b_mem_wmask byte_enable,

    // from memory.
    input lc3b_types::lc3b_cacheline_word mem_rdata,

    // to control.
    output logic hit_0,
    output logic hit_1,
    output logic hit_any,
    output logic dirty_out,
    output logic lru_out,

    // to the CPU and memory.
    output lc3b_types::lc3b_word cpu_rdata,
    output lc3b_types::lc3b_word mem_address,
    output lc3b_types::lc3b_cacheline_word mem_wdata
);

    import lc3b_types::*;

    lc3b_address cpu_addr;
    lc3b_address line_addr;
    lc3b_cacheline_tag victim_tag;
    logic lru_bit;

    cacheline_if line0_if ();
    cacheline_if line1_if ();

    always_comb cpu_addr.word = cpu_address;  // split into tag and offset below.

    // --------------------
    // LRU register
    // --------------------

    // it names the way to evict next.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lru_bit <= 1'b0;
        end else if (load_lru) begin
            lru_bit <= lru_in;
        end
    end

    assign lru_out = lru_bit;

    // --------------------
    // line inputs
    // --------------------

    // both ways see the same request; only the selected way gets a load strobe.
    assign line0_if.load = load & ~cacheline_sel;
    assign line1_if.load = load & cacheline_sel;
    assign line0_if.load_all = load_all & ~cacheline_sel;
    assign line1_if.load_all = load_all & cacheline_sel;

    assign line0_if.tag_in = cpu_addr.fields.tag;
    assign line1_if.tag_in = cpu_addr.fields.tag;
    assign line0_if.offset = cpu_addr.fields.offset;
    assign line1_if.offset = cpu_addr.fields.offset;
    assign line0_if.byte_enable = byte_enable;
    assign line1_if.byte_enable = byte_enable;
    assign line0_if.data_in = cpu_wdata;
    assign line1_if.data_in = cpu_wdata;
    assign line0_if.data_all_in = mem_rdata;
    assign line1_if.data_all_in = mem_rdata;

    cacheline_128 line0 (
        .clk,
        .rst_n,
        .port(line0_if.line)
    );

    cacheline_128 line1 (
        .clk,
        .rst_n,
        .port(line1_if.line)
    );

    // --------------------
    // result selection
    // --------------------
    assign hit_0 = line0_if.hit;
    assign hit_1 = line1_if.hit;
    assign hit_any = hit_0 | hit_1;

    assign cpu_rdata = cacheline_sel ? line1_if.data_out : line0_if.data_out;
    assign mem_wdata = cacheline_sel ? line1_if.data_all_out : line0_if.data_all_out;
    assign dirty_out = lru_bit ? line1_if.dirty : line0_if.dirty;  // victim is the LRU way.
    assign victim_tag = cacheline_sel ? line1_if.tag_out : line0_if.tag_out;

    // A write-back goes to the stored tag, a refill to the CPU tag.
    always_comb begin
        line_addr.fields.tag = tag_source_sel ? cpu_addr.fields.tag : victim_tag;
        line_addr.fields.offset = '0;  // memory moves whole lines.
        line_addr.fields.byte_sel = 1'b0;
    end

    assign mem_address = line_addr.word;

endmodule : cache_datapath

`default_nettype wire

//--- src/cache_control.sv
`timescale 1ns/100ps
`default_nettype none

module cache_control (
    input logic clk,
    input logic rst_n,

    // CPU request levels.
    input logic cpu_read,
    input logic cpu_write,

    // status from the datapath.
    input logic hit_0,
    input logic hit_1,
    input logic hit_any,
    input logic dirty_out,
    input logic lru_out,

    input logic mem_resp,

    // datapath controls.
    output logic cacheline_sel,
    output logic tag_source_sel,
    output logic load,
    output logic load_all,
    output logic load_lru,
    output logic lru_in,

    // handshake strobes.
    output logic cpu_resp,
    output logic mem_read,
    output logic mem_write
);

    // --------------------
    // state encoding
    // --------------------
    localparam logic [1:0] CHECK = 2'd0;
    localparam logic [1:0] WRITEBACK = 2'd1;
    localparam logic [1:0] ALLOCATE = 2'd2;

    logic [1:0] state;
    logic [1:0] next_state;
    logic request;

    assign request = cpu_read | cpu_write;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= CHECK;
        end else begin
            state <= next_state;
        end
    end

    // --------------------
    // next state and outputs
    // --------------------
    always_comb begin
        next_state = state;
        cacheline_sel = lru_out;  // the miss states always work on the victim way.
        tag_source_sel = 1'b0;
        load = 1'b0;
        load_all = 1'b0;
        load_lru = 1'b0;
        lru_in = 1'b0;
        cpu_resp = 1'b0;
        mem_read = 1'b0;
        mem_write = 1'b0;

        case (state)
            CHECK: begin
                cacheline_sel = hit_1;  // read from whichever way matched.
                if (request) begin
                    if (hit_any) begin
                        cpu_resp = 1'b1;
                        load_lru = 1'b1;
                        lru_in = hit_0;      // point at the way that did not hit.
                        load = cpu_write;    // commits at the closing edge.
                    end else if (dirty_out) begin
                        next_state = WRITEBACK;
                    end else begin
                        next_state = ALLOCATE;
                    end
                end
            end

            WRITEBACK: begin
                // the victim line leaves under its own stored tag.
                mem_write = 1'b1;
                if (mem_resp) begin
                    next_state = ALLOCATE;
                end
            end

            ALLOCATE: begin
                tag_source_sel = 1'b1;  // fetch the line the CPU asked for.
                mem_read = 1'b1;
                if (mem_resp) begin
                    load_all = 1'b1;
                    next_state = CHECK;  // the retried request now hits.
                end
            end

            default: begin
                next_state = CHECK;
            end
        endcase
    end

endmodule : cache_control

`default_nettype wire

//--- src/cache.sv
`timescale 1ns/100ps
`default_nettype none

module cache (
    input logic clk,
    input logic rst_n,

    // --------------------
    // CPU side
    // --------------------
    input logic cpu_read,
    input logic cpu_write,
    input lc3b_types::lc3b_word cpu_address,
    input lc3b_types::lc3b_word cpu_wdata,
    input lc3b_types::lc3b_mem_wmask cpu_wmask,
    output lc3b_types::lc3b_word cpu_rdata,
    output logic cpu_resp,

    // --------------------
    // memory side
    // --------------------
    output logic mem_read,
    output logic mem_write,
    output lc3b_types::lc3b_word mem_address,
    output lc3b_types::lc3b_cacheline_word mem_wdata,
    input lc3b_types::lc3b_cacheline_word mem_rdata,
    input logic mem_resp
);

    // control to datapath.
    logic cacheline_sel;
    logic tag_source_sel;
    logic load;
    logic load_all;
    logic load_lru;
    logic lru_in;

    // datapath back to control.
    logic hit_0;
    logic hit_1;
    logic hit_any;
    logic dirty_out;
    logic lru_out;

    cache_control control (
        .clk,
        .rst_n,
        .cpu_read,
        .cpu_write,
        .hit_0,
        .hit_1,
        .hit_any,
        .dirty_out,
        .lru_out,
        .mem_resp,
        .cacheline_sel,
        .tag_source_sel,
        .load,
        .load_all,
        .load_lru,
        .lru_in,
        .cpu_resp,
        .mem_read,
        .mem_write
    );

    cache_datapath datapath (
        .clk,
        .rst_n,
        .cacheline_sel,
        .tag_source_sel,
        .load,
        .load_all,
        .load_lru,
        .lru_in,
        .cpu_address,
        .cpu_wdata,
        .byte_enable(cpu_wmask),
        .mem_rdata,
        .hit_0,
        .hit_1,
        .hit_any,
        .dirty_out,
        .lru_out,
        .cpu_rdata,
        .mem_address,
        .mem_wdata
    );

endmodule : cache

`default_nettype wire

//--- verif/cache_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cache_tb;

    import lc3b_types::*;

    localparam int CYCLES_PER_TEST = 16;  // a write-back plus a refill fits well inside this.
    localparam int CYCLE_MARGIN = 100;

    logic clk;
    logic rst_n;
    logic cpu_read;
    logic cpu_write;
    lc3b_word cpu_address;
    lc3b_word cpu_wdata;
    lc3b_mem_wmask cpu_wmask;
    lc3b_word cpu_rdata;
    logic cpu_resp;
    logic mem_read;
    logic mem_write;
    lc3b_word mem_address;
    lc3b_cacheline_word mem_wdata;
    lc3b_cacheline_word mem_rdata;
    logic mem_resp;

    // --------------------
    // test table, one entry per stimulus line
    // --------------------
    string test_names[$];
    string test_ops[$];
    lc3b_word test_addrs[$];
    lc3b_word test_wdata[$];
    lc3b_mem_wmask test_masks[$];
    lc3b_word test_expect[$];
    int test_refills[$];
    int test_writebacks[$];
    lc3b_word test_wb_addrs[$];

    // line memory behind the cache, one entry per 16-bit word.
    lc3b_word memory [0:32767];
    int refill_count;
    int writeback_count;
    lc3b_word writeback_addrs[$];
    logic [31:0] lfsr_state;

    int cycle_count;
    int cycle_limit;
    string current_name;
    int test_errors;
    int tests_passed;
    int tests_failed;
    int load_errors;

    cache DUT (
        .clk,
        .rst_n,
        .cpu_read,
        .cpu_write,
        .cpu_address,
        .cpu_wdata,
        .cpu_wmask,
        .cpu_rdata,
        .cpu_resp,
        .mem_read,
        .mem_write,
        .mem_address,
        .mem_wdata,
        .mem_rdata,
        .mem_resp
    );

    always #20 clk = ~clk;  // 40 ns period.

    // --------------------
    // helpers
    // --------------------

    // Galois form, taps for x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end else begin
            return state >> 1;
        end
    endfunction

    task automatic take_random_bits(input int count, output int value);
        value = 0;
        for (int b = 0; b < count; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};  // one step per bit taken.
        end
    endtask

    task automatic check_value(input string what, input lc3b_word expected,
                               input lc3b_word actual);
        if (expected !== actual) begin
            $display("Fail %0s %0s: expected %h, actual %h", current_name, what,
                     expected, actual);
            test_errors++;
        end
    endtask

    task automatic load_stimulus;
        int fd;
        int count;
        string line;
        string name;
        string op;
        lc3b_word addr;
        lc3b_word wdata;
        lc3b_word expected_word;
        lc3b_word wb_addr;
        lc3b_mem_wmask mask;
        int refills;
        int writebacks;
        fd = $fopen("verif/cache_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file verif/cache_stimulus.txt");
            load_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                count = $sscanf(line, "%s %s %h %h %b %h %d %d %h", name, op, addr, wdata,
                                mask, expected_word, refills, writebacks, wb_addr);
                if (line.getc(0) != "#" && count > 0) begin  // skips comments and blanks.
                    if (count == 9 && (op == "R" || op == "W")) begin
                        test_names.push_back(name);
                        test_ops.push_back(op);
                        test_addrs.push_back(addr);
                        test_wdata.push_back(wdata);
                        test_masks.push_back(mask);
                        test_expect.push_back(expected_word);
                        test_refills.push_back(refills);
                        test_writebacks.push_back(writebacks);
                        test_wb_addrs.push_back(wb_addr);
                    end else begin
                        $display("the stimulus line '%0s' could not be read", name);
                        load_errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // one CPU request, held until cpu_resp and released after the closing edge.
    task automatic run_test(input int idx);
        int refills_before;
        int writebacks_before;
        lc3b_word read_word;
        current_name = test_names[idx];
        test_errors = 0;
        refills_before = refill_count;
        writebacks_before = writeback_count;
        @(posedge clk);
        #2;
        cpu_read = (test_ops[idx] == "R");
        cpu_write = (test_ops[idx] == "W");
        cpu_address = test_addrs[idx];
        cpu_wdata = test_wdata[idx];
        cpu_wmask = test_masks[idx];
        @(negedge clk);
        while (!cpu_resp) begin
            @(negedge clk);
        end
        read_word = cpu_rdata;
        if (cpu_read) begin
            check_value("read data", test_expect[idx], read_word);
        end
        check_value("refills", 16'(test_refills[idx]), 16'(refill_count - refills_before));
        check_value("write-backs", 16'(test_writebacks[idx]),
                    16'(writeback_count - writebacks_before));
        if (test_writebacks[idx] > 0 && writeback_count > writebacks_before) begin
            check_value("write-back address", test_wb_addrs[idx], writeback_addrs[$]);
        end
        if (test_errors == 0) begin
            $display("test %0s passed", current_name);
            tests_passed++;
        end else begin
            $display("test %0s failed with %0d errors", current_name, test_errors);
            tests_failed++;
        end
    endtask

    // --------------------
    // line memory model
    // --------------------

    // Requests are seen mid-cycle and answered after 1 to 4 cycles.
    always begin
        int delay;
        logic [14:0] base;
        @(negedge clk);
        if (rst_n && (mem_read || mem_write)) begin
            take_random_bits(2, delay);
            delay = delay + 1;
            repeat (delay) @(posedge clk);
            #2;
            base = mem_address[15:1];  // word address of word 0 in the line.
            if (mem_write) begin
                for (int i = 0; i < 8; i++) begin
                    memory[base + 15'(i)] = mem_wdata[i*16 +: 16];
                end
                writeback_count++;
                writeback_addrs.push_back(mem_address);
            end else begin
                for (int i = 0; i < 8; i++) begin
                    mem_rdata[i*16 +: 16] = memory[base + 15'(i)];
                end
                refill_count++;
            end
            mem_resp = 1'b1;
            @(posedge clk);
            #2;
            mem_resp = 1'b0;
        end
    end

    // --------------------
    // watchdog
    // --------------------
    always @(posedge clk) begin
        if (cycle_count >= cycle_limit) begin
            $display("timeout: test %0s got no cpu_resp within %0d cycles", current_name,
                     cycle_limit);
            $display("Something failed");
            $finish;
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        cpu_read = 1'b0;
        cpu_write = 1'b0;
        cpu_address = '0;
        cpu_wdata = '0;
        cpu_wmask = '0;
        mem_rdata = '0;
        mem_resp = 1'b0;
        lfsr_state = 32'd84626;
        refill_count = 0;
        writeback_count = 0;
        cycle_count = 0;
        cycle_limit = CYCLE_MARGIN;
        current_name = "reset";
        tests_passed = 0;
        tests_failed = 0;
        load_errors = 0;
        for (int a = 0; a < 32768; a++) begin
            memory[a[14:0]] = a[15:0] ^ 16'h5A5A;  // each word is its word address XOR 5A5A.
        end
        load_stimulus();
        cycle_limit = test_names.size() * CYCLES_PER_TEST + CYCLE_MARGIN;

        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;

        for (int i = 0; i < test_names.size(); i++) begin
            run_test(i);
        end
        @(posedge clk);
        #2;
        cpu_read = 1'b0;
        cpu_write = 1'b0;

        $display("tests run %0d, passed %0d, failed %0d", test_names.size(), tests_passed,
                 tests_failed);
        if (load_errors == 0 && tests_failed == 0 && tests_passed > 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule : cache_tb

`default_nettype wire

//--- verif/cache_stimulus.txt
# name op address wdata mask(bin) expected refills(dec) writebacks(dec) writeback_address
# write rows leave expected at 0000, it is not compared for them.
cold_read               R 1234 0000 00 5340 1 0 0000
same_line_hit           R 123c 0000 00 5344 0 0 0000
write_low_byte          W 1236 beef 01 0000 0 0 0000
readback_low_byte       R 1236 0000 00 53ef 0 0 0000
write_high_byte         W 1238 cafe 10 0000 0 0 0000
readback_high_byte      R 1238 0000 00 ca46 0 0 0000
write_full_word         W 123a 1357 11 0000 0 0 0000
readback_full_word      R 123a 0000 00 1357 0 0 0000
touch_b                 R 4562 0000 00 78eb 1 0 0000
touch_a_again           R 1230 0000 00 5342 0 0 0000
miss_c_evicts_b         R 789e 0000 00 6615 1 0 0000
a_still_hits            R 123a 0000 00 1357 0 0 0000
touch_c                 R 7890 0000 00 6612 0 0 0000
evict_dirty_a           R abc4 0000 00 0fb8 1 1 1230
reread_a_low_byte       R 1236 0000 00 53ef 1 0 0000
reread_a_high_byte      R 1238 0000 00 ca46 0 0 0000
reread_a_full_word      R 123a 0000 00 1357 0 0 0000
reread_a_clean_word     R 1234 0000 00 5340 0 0 0000
write_miss              W 2002 a55a 11 0000 1 0 0000
read_after_write_miss   R 2002 0000 00 a55a 0 0 0000
touch_a_clean           R 1230 0000 00 5342 0 0 0000
evict_dirty_e           R 3000 0000 00 425a 1 1 2000
reread_e                R 2002 0000 00 a55a 1 0 0000
reread_e_neighbor       R 2000 0000 00 4a5a 0 0 0000
high_address            R fffe 0000 00 25a5 1 0 0000

//--- cache.f
+incdir+src
src/lc3b_types.sv
src/cacheline_if.sv
src/cacheline_128.sv
src/cache_datapath.sv
src/cache_control.sv
src/cache.sv
verif/cache_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the cache testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
    --top-module cache_tb --Mdir obj_dir -o cache_sim \
    -f cache.f

./obj_dir/cache_sim | tee sim.log

if grep -q "Everything OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
